// ==== bench/glue_monitor_props.sv ====
// Concurrent checks on the APB response and irq, bound into the glue-chain monitor top level

`timescale 1ns/10ps

module glue_monitor_props (
    // Bus clock of the monitor
    input logic                 clk,
    // Synchronous active-high reset
    input logic                 rst,
    // Request seen on the APB port
    input glue_pkg::apb_req_t   apb_req,
    // Response driven by the register file
    input glue_pkg::apb_rsp_t   apb_rsp,
    // Synchronized status inside the top level
    input glue_pkg::chain_vec_t status,
    // Interrupt output
    input logic                 irq
);

    // The register file never inserts wait states
    pready_high: assert property (@(posedge clk) apb_rsp.pready)
        else $error("pready was low on a bus clock edge");

    // An error response belongs to an access phase only
    pslverr_in_access: assert property (
        @(posedge clk) apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable)
    ) else $error("pslverr was high outside an access phase");

    // Reset clears the interrupt register
    irq_low_after_rst: assert property (@(posedge clk) rst |=> !irq)
        else $error("irq was high in the cycle after reset");

    // irq is the registered OR of status
    // The first edge after reset is skipped since irq was loaded by reset there
    irq_tracks_status: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> (irq == (|$past(status)))
    ) else $error("irq did not match the status of the previous bus clock edge");

endmodule

// Every glue_monitor instance carries these checks on its own internal status
bind glue_monitor glue_monitor_props props_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .status  (status),
    .irq     (irq)
);

// ==== bench/glue_monitor_tb.sv ====
// Testbench that drives the glue-chain monitor over APB and checks status, irq and bus errors

`timescale 1ns/10ps

module glue_monitor_tb;

    // Half periods of the bus clock and the system clock
    localparam int CLK_HALF = 20;
    localparam int SYS_HALF = 15;

    // Longest wait for one event covers the chain walk and capture, then sync and irq
    localparam int EVENT_BOUND_NS =
        (glue_pkg::CHAIN_LEN + 4) * 2 * SYS_HALF + 4 * 2 * CLK_HALF;

    // A test waits for at most four events including its bus traffic
    localparam int TEST_BOUND_NS = 4 * EVENT_BOUND_NS;
    localparam int TEST_COUNT    = 6;
    localparam int WATCHDOG_NS   = 20 * TEST_COUNT * TEST_BOUND_NS;

    logic               clk = 1'b0;
    logic               clksys = 1'b0;
    logic               rst;
    logic               scan_mode;
    glue_pkg::apb_req_t apb_req;
    glue_pkg::apb_rsp_t apb_rsp;
    logic               irq;

    // Error count of the running test and the totals
    int test_errors;
    int pass_count;
    int fail_count;

    glue_monitor dut_i (
        .clk       (clk),
        .clksys    (clksys),
        .rst       (rst),
        .scan_mode (scan_mode),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .irq       (irq)
    );

    // The two clocks are unrelated so status really crosses domains
    always #(CLK_HALF) clk = ~clk;
    always #(SYS_HALF) clksys = ~clksys;

    // All bus tasks start and end on a falling clk edge
    task automatic apb_write(input glue_pkg::apb_addr_t addr, input glue_pkg::apb_data_t data);
        logic err;
        // Setup phase
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        apb_req.pwrite  = 1'b1;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        // Access phase that completes on the next rising edge
        apb_req.penable = 1'b1;
        // Every write here targets a defined offset, so pslverr has to stay low
        #(CLK_HALF / 2);
        err = apb_rsp.pslverr;
        check_value("pslverr", '0, {31'b0, err});
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input glue_pkg::apb_addr_t addr,
                            output glue_pkg::apb_data_t data, output logic err);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        // prdata is combinational, so sample midway through the low phase
        #(CLK_HALF / 2);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic check_value(input string name, input glue_pkg::apb_data_t exp,
                               input glue_pkg::apb_data_t got);
        assert (got === exp) else begin
            $display("Fail %s expected 0x%08h got 0x%08h", name, exp, got);
            test_errors++;
        end
    endtask

    // Reads one register and checks its value and the error flag
    task automatic check_read(input glue_pkg::apb_addr_t addr, input string name,
                              input glue_pkg::apb_data_t exp, input logic exp_err);
        glue_pkg::apb_data_t data;
        logic                err;
        apb_read(addr, data, err);
        check_value(name, exp, data);
        check_value("pslverr", {31'b0, exp_err}, {31'b0, err});
    endtask

    task automatic check_irq(input logic exp);
        assert (irq === exp) else begin
            $display("Fail irq expected 0x%0h got 0x%0h", exp, irq);
            test_errors++;
        end
    endtask

    // Waits for irq to reach a level and gives up after one event bound
    task automatic wait_irq(input logic level, input string what);
        int waited;
        waited = 0;
        while (irq !== level && waited < EVENT_BOUND_NS) begin
            @(negedge clk);
            waited += 2 * CLK_HALF;
        end
        assert (irq === level) else begin
            $display("The %s did not arrive within %0d ns", what, EVENT_BOUND_NS);
            test_errors++;
        end
    endtask

    // Lets a full event bound pass when the check is that nothing happens
    task automatic settle();
        repeat (EVENT_BOUND_NS / (2 * CLK_HALF)) @(negedge clk);
    endtask

    function automatic glue_pkg::chain_vec_t chain_bit(input int k);
        return glue_pkg::chain_vec_t'(1) << k;
    endfunction

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_reset_values();
        check_read(glue_pkg::REG_MASK_OFS, "mask", '0, 1'b0);
        check_read(glue_pkg::REG_STATUS_OFS, "status", '0, 1'b0);
        check_read(glue_pkg::REG_ENABLE_OFS, "enable", '0, 1'b0);
        check_read(glue_pkg::REG_TEST_OFS, "test", '0, 1'b0);
        check_irq(1'b0);
        finish_test("[1] reset values");
    endtask

    task automatic test_register_access();
        glue_pkg::apb_data_t mask_val;
        glue_pkg::apb_data_t enable_val;
        glue_pkg::apb_data_t test_val;
        mask_val   = $urandom();
        enable_val = $urandom();
        test_val   = $urandom();
        apb_write(glue_pkg::REG_MASK_OFS, mask_val);
        apb_write(glue_pkg::REG_TEST_OFS, test_val);
        apb_write(glue_pkg::REG_ENABLE_OFS, enable_val);
        check_read(glue_pkg::REG_MASK_OFS, "mask", mask_val, 1'b0);
        check_read(glue_pkg::REG_ENABLE_OFS, "enable", enable_val, 1'b0);
        check_read(glue_pkg::REG_TEST_OFS, "test", test_val, 1'b0);
        // Some chains may have fired, so put every chain back into reset
        apb_write(glue_pkg::REG_ENABLE_OFS, '0);
        apb_write(glue_pkg::REG_TEST_OFS, '0);
        apb_write(glue_pkg::REG_MASK_OFS, '0);
        settle();
        // Status is read only and a write there is not an error
        apb_write(glue_pkg::REG_STATUS_OFS, '1);
        check_read(glue_pkg::REG_STATUS_OFS, "status", '0, 1'b0);
        // The status write must not land in any control register either
        check_read(glue_pkg::REG_MASK_OFS, "mask", '0, 1'b0);
        check_read(glue_pkg::REG_ENABLE_OFS, "enable", '0, 1'b0);
        check_read(glue_pkg::REG_TEST_OFS, "test", '0, 1'b0);
        check_irq(1'b0);
        check_read(12'h010, "prdata", '0, 1'b1);
        finish_test("[2] register access");
    endtask

    task automatic test_self_test(input int k);
        apb_write(glue_pkg::REG_ENABLE_OFS, chain_bit(k));
        apb_write(glue_pkg::REG_TEST_OFS, chain_bit(k));
        wait_irq(1'b1, "irq from the self-test chain");
        // Only the chain under test may report
        check_read(glue_pkg::REG_STATUS_OFS, "status", chain_bit(k), 1'b0);
        finish_test($sformatf("[3] self test on chain %0d", k));
    endtask

    task automatic test_sticky_clear(input int k);
        apb_write(glue_pkg::REG_TEST_OFS, '0);
        settle();
        // The cells latched the hit, so removing the test bit changes nothing
        check_irq(1'b1);
        check_read(glue_pkg::REG_STATUS_OFS, "status", chain_bit(k), 1'b0);
        apb_write(glue_pkg::REG_ENABLE_OFS, '0);
        wait_irq(1'b0, "irq release after disabling the chain");
        check_read(glue_pkg::REG_STATUS_OFS, "status", '0, 1'b0);
        finish_test($sformatf("[4] sticky status and clear on chain %0d", k));
    endtask

    task automatic test_masking(input int k);
        apb_write(glue_pkg::REG_MASK_OFS, chain_bit(k));
        apb_write(glue_pkg::REG_ENABLE_OFS, chain_bit(k));
        apb_write(glue_pkg::REG_TEST_OFS, chain_bit(k));
        settle();
        check_irq(1'b0);
        check_read(glue_pkg::REG_STATUS_OFS, "status", '0, 1'b0);
        // The chain end is already high, so unmasking shows it at once
        apb_write(glue_pkg::REG_MASK_OFS, '0);
        wait_irq(1'b1, "irq after clearing the mask");
        check_read(glue_pkg::REG_STATUS_OFS, "status", chain_bit(k), 1'b0);
        apb_write(glue_pkg::REG_ENABLE_OFS, '0);
        apb_write(glue_pkg::REG_TEST_OFS, '0);
        wait_irq(1'b0, "irq release after the masking test");
        finish_test($sformatf("[5] masking on chain %0d", k));
    endtask

    task automatic test_scan_mode();
        scan_mode = 1'b1;
        apb_write(glue_pkg::REG_ENABLE_OFS, '1);
        apb_write(glue_pkg::REG_TEST_OFS, '1);
        settle();
        check_irq(1'b0);
        check_read(glue_pkg::REG_STATUS_OFS, "status", '0, 1'b0);
        // Disable everything before scan mode ends so no chain fires afterwards
        apb_write(glue_pkg::REG_TEST_OFS, '0);
        apb_write(glue_pkg::REG_ENABLE_OFS, '0);
        scan_mode = 1'b0;
        finish_test("[6] scan mode");
    endtask

    // Ends a run that hangs somewhere in the tests
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        int k;
        void'($urandom(32'h12ae2706));
        rst         = 1'b1;
        scan_mode   = 1'b0;
        apb_req     = '0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        // Three rising clk edges with reset high
        repeat (3) @(negedge clk);
        rst = 1'b0;

        test_reset_values();
        test_register_access();
        k = $urandom % glue_pkg::CHAIN_COUNT;
        test_self_test(k);
        test_sticky_clear(k);
        k = $urandom % glue_pkg::CHAIN_COUNT;
        test_masking(k);
        test_scan_mode();

        $display("Summary: %0d passed, %0d with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/glue_pkg.sv
hdl/glue_cell.sv
hdl/glue_chain_row.sv
hdl/glue_apb_regs.sv
hdl/glue_monitor.sv
bench/glue_monitor_props.sv
bench/glue_monitor_tb.sv

// ==== hdl/glue_apb_regs.sv ====
// APB register file holding mask, enable and test, with status synchronization and read-back

`timescale 1ns/10ps

module glue_apb_regs (
    // Bus clock
    input  logic                clk,
    // Synchronous active-high reset
    input  logic                rst,
    // Request from the bus master
    input  glue_pkg::apb_req_t  apb_req,
    // Response to the bus master
    output glue_pkg::apb_rsp_t  apb_rsp,
    // Chain status still in the clksys domain
    input  glue_pkg::chain_vec_t status_sys,
    // Per-chain mask toward the rows
    output glue_pkg::chain_vec_t mask,
    // Per-chain enable toward the rows
    output glue_pkg::chain_vec_t enable,
    // Per-chain self-test toward the rows
    output glue_pkg::chain_vec_t test,
    // Status after the synchronizer, in the clk domain
    output glue_pkg::chain_vec_t status
);

    // Control registers written by software
    glue_pkg::chain_vec_t mask_q;
    glue_pkg::chain_vec_t enable_q;
    glue_pkg::chain_vec_t test_q;

    // Two flop synchronizer for the status coming from clksys
    glue_pkg::chain_vec_t status_meta_q;
    glue_pkg::chain_vec_t status_sync_q;

    // Bus phase decode
    logic access;
    logic wr_en;

    // Per register write strobes
    logic wr_mask;
    logic wr_enable;
    logic wr_test;

    // Read mux result and address match flag
    glue_pkg::apb_data_t rd_data;
    logic                addr_hit;

    // Access phase is psel and penable together
    // pready is always high so every access phase completes on its edge
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    // Writes only land on the three writable offsets
    // Status and unmapped offsets get no strobe, so a write there has no effect
    assign wr_mask   = wr_en && (apb_req.paddr == glue_pkg::REG_MASK_OFS);
    assign wr_enable = wr_en && (apb_req.paddr == glue_pkg::REG_ENABLE_OFS);
    assign wr_test   = wr_en && (apb_req.paddr == glue_pkg::REG_TEST_OFS);

    // Mask register
    always_ff @(posedge clk) begin
        if (rst) begin
            mask_q <= '0;
        end else if (wr_mask) begin
            mask_q <= apb_req.pwdata;
        end
    end

    // Enable register where a cleared bit puts its chain back into reset
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= '0;
        end else if (wr_enable) begin
            enable_q <= apb_req.pwdata;
        end
    end

    // Test register
    always_ff @(posedge clk) begin
        if (rst) begin
            test_q <= '0;
        end else if (wr_test) begin
            test_q <= apb_req.pwdata;
        end
    end

    // Status crosses from clksys into clk through two flops
    // The first stage may go metastable and the second settles it
    always_ff @(posedge clk) begin
        if (rst) begin
            status_meta_q <= '0;
            status_sync_q <= '0;
        end else begin
            status_meta_q <= status_sys;
            status_sync_q <= status_meta_q;
        end
    end

    // Read mux over the four defined offsets
    // Anything else reads as zero and clears addr_hit
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (apb_req.paddr)
            glue_pkg::REG_MASK_OFS: begin
                rd_data = mask_q;
            end
            glue_pkg::REG_STATUS_OFS: begin
                rd_data = status_sync_q;
            end
            glue_pkg::REG_ENABLE_OFS: begin
                rd_data = enable_q;
            end
            glue_pkg::REG_TEST_OFS: begin
                rd_data = test_q;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // Read data is only presented in the access phase
    assign apb_rsp.prdata = access ? rd_data : '0;

    // No wait states
    assign apb_rsp.pready = 1'b1;

    // Unmapped offsets raise an error in the access phase only
    // A write to status hits a defined offset and is not an error
    assign apb_rsp.pslverr = access & ~addr_hit;

    // Register values toward the chain rows
    assign mask   = mask_q;
    assign enable = enable_q;
    assign test   = test_q;

    // Synchronized status drives the interrupt logic in the top level
    assign status = status_sync_q;

endmodule

// ==== hdl/glue_cell.sv ====
// Single sticky detector stage, placed in series to build one glue chain

`timescale 1ns/10ps

module glue_cell (
    // System clock that drives the chain logic
    input  logic clksys,
    // Chain reset that clears the latched detection while high
    input  logic chain_rst,
    // Detection arriving from the previous stage or the chain head
    input  logic glue_in,
    // Detection passed on to the next stage
    output logic glue_out
);

    // Stands in for the analog tamper cell
    // A high on the input is latched and held until the chain is reset
    // Each stage therefore adds one clksys cycle of propagation delay
    logic hit_q;

    always_ff @(posedge clksys) begin
        if (chain_rst) begin
            // Chain held in reset, so nothing is latched
            hit_q <= 1'b0;
        end else begin
            // Once set the stage keeps its output high
            hit_q <= hit_q | glue_in;
        end
    end

    // The latched hit is the stage output
    assign glue_out = hit_q;

endmodule

// ==== hdl/glue_chain_row.sv ====
// One detector chain with its scan and reset gating and the masked status capture flop

`timescale 1ns/10ps

module glue_chain_row (
    // System clock for the cells and the capture flop
    input  logic clksys,
    // Synchronous active-high reset
    input  logic rst,
    // Scan mode silences the chain completely
    input  logic scan_mode,
    // Software enable that holds every cell in reset while low
    input  logic enable,
    // Software self-test bit that drives the chain head
    input  logic test,
    // Software mask that keeps the status bit at zero while high
    input  logic mask,
    // Captured chain status in the clksys domain
    output logic status
);

    // Net between stages where index 0 is the chain head
    // Index CHAIN_LEN is the far end of the chain
    logic [glue_pkg::CHAIN_LEN:0] glue_net;

    // Shared reset for every cell of this chain
    logic chain_rst;

    // Status bit before the capture flop
    logic status_d;

    // The test bit enters at the head unless scan mode is active
    assign glue_net[0] = scan_mode ? 1'b0 : test;

    // Cells are cleared on system reset, while the chain is disabled
    // and for the whole time scan mode is on
    assign chain_rst = rst | ~enable | scan_mode;

    // Cells placed in series so a detection walks one stage per cycle
    for (genvar j = 0; j < glue_pkg::CHAIN_LEN; j++) begin : g_cell
        glue_cell cell_i (
            .clksys    (clksys),
            .chain_rst (chain_rst),
            .glue_in   (glue_net[j]),
            .glue_out  (glue_net[j+1])
        );
    end

    // A masked chain or scan mode forces the captured value to zero
    assign status_d = (mask | scan_mode) ? 1'b0 : glue_net[glue_pkg::CHAIN_LEN];

    // Capture flop adds one more clksys cycle after the chain end
    always_ff @(posedge clksys) begin
        if (rst) begin
            status <= 1'b0;
        end else begin
            status <= status_d;
        end
    end

endmodule

// ==== hdl/glue_monitor.sv ====
// Top level of the tamper glue-chain monitor, joining the APB registers, chain rows and irq

`timescale 1ns/10ps

module glue_monitor (
    // Bus clock for APB, the synchronizer and irq
    input  logic               clk,
    // System clock for the detector chains
    input  logic               clksys,
    // Synchronous active-high reset, used in both domains
    input  logic               rst,
    // Scan mode silences every chain
    input  logic               scan_mode,
    // APB request from the bus master
    input  glue_pkg::apb_req_t apb_req,
    // APB response back to the bus master
    output glue_pkg::apb_rsp_t apb_rsp,
    // Interrupt while any unmasked chain reports
    output logic               irq
);

    // Register outputs toward the rows
    glue_pkg::chain_vec_t mask;
    glue_pkg::chain_vec_t enable;
    glue_pkg::chain_vec_t test;

    // Row status gathered in the clksys domain
    glue_pkg::chain_vec_t status_sys;

    // Row status after synchronization into clk
    glue_pkg::chain_vec_t status;

    // Register file and status synchronizer
    glue_apb_regs regs_i (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .status_sys (status_sys),
        .mask       (mask),
        .enable     (enable),
        .test       (test),
        .status     (status)
    );

    // One row per chain, each taking its own bit of every control vector
    for (genvar i = 0; i < glue_pkg::CHAIN_COUNT; i++) begin : g_row
        glue_chain_row row_i (
            .clksys    (clksys),
            .rst       (rst),
            .scan_mode (scan_mode),
            .enable    (enable[i]),
            .test      (test[i]),
            .mask      (mask[i]),
            .status    (status_sys[i])
        );
    end

    // Interrupt is the registered OR of the synchronized status
    // It follows status one clk edge later and clears with it
    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= |status;
        end
    end

endmodule

// ==== hdl/glue_pkg.sv ====
// Shared widths, register map, chain dimensions and APB structs for the glue-chain monitor

package glue_pkg;

    // Number of detector chains
    // One chain per bit, so all chain registers fit in one 32-bit word
    localparam int CHAIN_COUNT = 32;

    // Detector cells placed in series along each chain
    localparam int CHAIN_LEN = 8;

    // APB byte address width
    localparam int APB_ADDR_W = 12;

    // APB data width, which is also the register word width
    localparam int APB_DATA_W = 32;

    // One bit per chain for mask, enable, test and status
    typedef logic [CHAIN_COUNT-1:0] chain_vec_t;

    // Byte address seen on the APB port
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    // Read and write data word on the APB port
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // Register offsets inside the monitor's APB window
    // Mask bits force a chain's status to zero
    localparam apb_addr_t REG_MASK_OFS = 12'h000;

    // Captured and synchronized chain status that software can only read
    localparam apb_addr_t REG_STATUS_OFS = 12'h004;

    // Enable bits release each chain from reset
    localparam apb_addr_t REG_ENABLE_OFS = 12'h008;

    // Test bits drive a high into the head of each chain
    localparam apb_addr_t REG_TEST_OFS = 12'h00C;

    // Request fields driven by the bus master
    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    // Response fields driven by the register file
    // There are no wait states so pready stays high
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Builds the glue-chain monitor testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module glue_monitor_tb \
    -f files.f \
    -o glue_monitor_sim

output=$(./obj_dir/glue_monitor_sim)
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
